// File: design/Alu.sv
// RV32I integer ALU; shift amounts use the low 5 bits of the second operand
`timescale 1ns/1ps

module Alu (
  DecodeBus.consumer                    bus,
  input  logic [CorePkg::DataWidth-1:0] pc,
  input  logic [CorePkg::DataWidth-1:0] rs1Data,
  input  logic [CorePkg::DataWidth-1:0] rs2Data,
  output logic [CorePkg::DataWidth-1:0] aluResult
);

  logic [CorePkg::DataWidth-1:0] opA;
  logic [CorePkg::DataWidth-1:0] opB;
  logic [4:0] shamt;

  always_comb begin
    case (bus.opInfo.op1Sel)
      CorePkg::SelReg: opA = rs1Data;
      CorePkg::SelImm: opA = bus.imm;
      CorePkg::SelPc:  opA = pc;
      default:         opA = '0;
    endcase
    case (bus.opInfo.op2Sel)
      CorePkg::SelReg: opB = rs2Data;
      CorePkg::SelImm: opB = bus.imm;
      CorePkg::SelPc:  opB = pc;
      default:         opB = '0;
    endcase
  end

  assign shamt = opB[4:0];

  always_comb begin
    case (bus.opInfo.aluCode)
      CorePkg::AluAdd:  aluResult = opA + opB;
      CorePkg::AluSub:  aluResult = opA - opB;
      CorePkg::AluSll:  aluResult = opA << shamt;
      CorePkg::AluSlt:  aluResult = {31'b0, $signed(opA) < $signed(opB)};
      CorePkg::AluSltu: aluResult = {31'b0, opA < opB};
      CorePkg::AluXor:  aluResult = opA ^ opB;
      CorePkg::AluSrl:  aluResult = opA >> shamt;
      CorePkg::AluSra:  aluResult = $unsigned($signed(opA) >>> shamt);
      CorePkg::AluOr:   aluResult = opA | opB;
      CorePkg::AluAnd:  aluResult = opA & opB;
      default:          aluResult = opB;
    endcase
  end

endmodule

// File: design/BranchUnit.sv
// Branch condition only; the target is computed in CoreControl
`timescale 1ns/1ps

module BranchUnit (
  DecodeBus.consumer                    bus,
  input  logic [CorePkg::DataWidth-1:0] rs1Data,
  input  logic [CorePkg::DataWidth-1:0] rs2Data,
  output logic                          taken
);

  always_comb begin
    case (bus.opInfo.brCode)
      CorePkg::BrEq:  taken = rs1Data == rs2Data;
      CorePkg::BrNe:  taken = rs1Data != rs2Data;
      CorePkg::BrLt:  taken = $signed(rs1Data) < $signed(rs2Data);
      CorePkg::BrGe:  taken = $signed(rs1Data) >= $signed(rs2Data);
      CorePkg::BrLtu: taken = rs1Data < rs2Data;
      CorePkg::BrGeu: taken = rs1Data >= rs2Data;
      default:        taken = 1'b0;
    endcase
  end

endmodule

// File: design/CoreControl.sv
// One instruction in flight: 2 cycles, stores 3, loads 4; fetchData must answer in the same cycle
`timescale 1ns/1ps

module CoreControl (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [31:0]                   fetchData,
  input  logic [CorePkg::DataWidth-1:0] aluResult,
  input  logic [CorePkg::DataWidth-1:0] loadData,
  input  logic                          taken,
  DecodeBus.consumer                    bus,
  output logic [CorePkg::DataWidth-1:0] fetchAddr,
  output logic [31:0]                   instB,
  output logic [CorePkg::DataWidth-1:0] pc,
  output logic                          regWrite,
  output logic [CorePkg::DataWidth-1:0] regWriteData,
  output logic                          memRead,
  output logic                          memWrite,
  output logic                          retire,
  output logic [CorePkg::DataWidth-1:0] retirePc,
  output logic                          retireWrite,
  output CorePkg::RegAddr               retireRd,
  output logic [CorePkg::DataWidth-1:0] retireData
);

  CorePkg::CoreState state;
  logic memOp;
  logic [CorePkg::DataWidth-1:0] pcPlus4;
  logic [CorePkg::DataWidth-1:0] nextPc;

  assign memOp = bus.opInfo.isLoad || bus.opInfo.isStore;
  assign pcPlus4 = pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= CorePkg::StFetch;
      pc <= CorePkg::ResetPc;
    end else begin
      case (state)
        CorePkg::StFetch:   state <= CorePkg::StExecute;
        CorePkg::StExecute: state <= memOp ? CorePkg::StMemory : CorePkg::StFetch;
        CorePkg::StMemory:  state <= bus.opInfo.isLoad ? CorePkg::StWriteback : CorePkg::StFetch;
        default:            state <= CorePkg::StFetch;
      endcase
      if (retire) begin
        pc <= nextPc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == CorePkg::StFetch) begin
      instB <= fetchData;
    end
  end

  always_comb begin
    if (bus.opInfo.isJalr) begin
      nextPc = {aluResult[CorePkg::DataWidth-1:1], 1'b0};
    end else if (bus.opInfo.isJump || taken) begin
      nextPc = pc + bus.imm;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // Writeback source
  always_comb begin
    if (bus.opInfo.isJump) begin
      regWriteData = pcPlus4;
    end else if (bus.opInfo.isLoad) begin
      regWriteData = loadData;
    end else begin
      regWriteData = aluResult;
    end
  end

  assign fetchAddr = pc;

  assign retire = (state == CorePkg::StExecute && !memOp) ||
                  (state == CorePkg::StMemory && bus.opInfo.isStore) ||
                  (state == CorePkg::StWriteback);

  // x0 destinations are dropped here
  assign regWrite = retire && bus.opInfo.wEnable && bus.rdAddr != CorePkg::RegNone;

  assign memRead = state == CorePkg::StMemory && bus.opInfo.isLoad;
  assign memWrite = state == CorePkg::StMemory && bus.opInfo.isStore;

  assign retirePc = pc;
  assign retireWrite = regWrite;
  assign retireRd = bus.rdAddr;
  assign retireData = regWriteData;

endmodule

// File: design/CorePkg.sv
// Shared RV32I definitions; the core has no M extension, no CSR and no exceptions
package CorePkg;

  localparam int DataWidth = 32;
  localparam int RegCount = 32;
  localparam int DataMemWords = 256;
  localparam logic [DataWidth-1:0] ResetPc = 32'h0000_0000;

  typedef logic [4:0] RegAddr;

  localparam RegAddr RegNone = 5'd0;

  // Major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    OpcOpImm  = 7'b0010011,
    OpcOp     = 7'b0110011,
    OpcLui    = 7'b0110111,
    OpcAuipc  = 7'b0010111,
    OpcJal    = 7'b1101111,
    OpcJalr   = 7'b1100111,
    OpcBranch = 7'b1100011,
    OpcLoad   = 7'b0000011,
    OpcStore  = 7'b0100011
  } OpCode;

  typedef enum logic [3:0] {
    AluAdd = 4'd0,
    AluSub,
    AluSll,
    AluSlt,
    AluSltu,
    AluXor,
    AluSrl,
    AluSra,
    AluOr,
    AluAnd,
    AluPassB
  } AluCode;

  typedef enum logic [1:0] {
    SelReg = 2'd0,
    SelImm,
    SelPc,
    SelZero
  } OperandSel;

  typedef enum logic [2:0] {
    BrNone = 3'd0,
    BrEq,
    BrNe,
    BrLt,
    BrGe,
    BrLtu,
    BrGeu
  } BrCode;

  typedef enum logic [2:0] {
    MemNone = 3'd0,
    MemByte,
    MemHalf,
    MemWord,
    MemByteU,
    MemHalfU
  } MemWidth;

  typedef enum logic [1:0] {
    StFetch,
    StExecute,
    StMemory,
    StWriteback
  } CoreState;

  typedef struct packed {
    AluCode    aluCode;
    OperandSel op1Sel;
    OperandSel op2Sel;
    BrCode     brCode;
    MemWidth   memWidth;
    logic      wEnable;
    logic      isJump;
    logic      isJalr;
    logic      isLoad;
    logic      isStore;
    logic      isBubble;
  } OpInfo;

endpackage

// File: design/DataMemory.sv
// 256 words, address wraps on bits 9:2; misaligned accesses shift by the low address bits as given
`timescale 1ns/1ps

module DataMemory (
  input  logic                          clk,
  input  logic                          memRead,
  input  logic                          memWrite,
  input  logic [CorePkg::DataWidth-1:0] address,
  input  logic [CorePkg::DataWidth-1:0] rs2Data,
  DecodeBus.consumer                    bus,
  output logic [CorePkg::DataWidth-1:0] loadData
);

  logic [CorePkg::DataWidth-1:0] mem [CorePkg::DataMemWords];
  logic [7:0] wordIdx;
  logic [4:0] laneShift;
  logic [3:0] byteEn;
  logic [CorePkg::DataWidth-1:0] writeWord;
  logic [CorePkg::DataWidth-1:0] readWord;

  assign wordIdx = address[9:2];
  assign laneShift = {address[1:0], 3'b000};

  always_comb begin
    case (bus.opInfo.memWidth)
      CorePkg::MemByte: byteEn = 4'b0001 << address[1:0];
      CorePkg::MemHalf: byteEn = 4'b0011 << address[1:0];
      CorePkg::MemWord: byteEn = 4'b1111;
      default:          byteEn = 4'b0000;
    endcase
  end

  assign writeWord = rs2Data << laneShift;

  always_ff @(posedge clk) begin
    if (memWrite) begin
      for (int b = 0; b < 4; b++) begin
        if (byteEn[b]) begin
          mem[wordIdx][8*b +: 8] <= writeWord[8*b +: 8];
        end
      end
    end
    // Addressed byte lands in lane 0
    if (memRead) begin
      readWord <= mem[wordIdx] >> laneShift;
    end
  end

  always_comb begin
    case (bus.opInfo.memWidth)
      CorePkg::MemByte:  loadData = {{24{readWord[7]}}, readWord[7:0]};
      CorePkg::MemHalf:  loadData = {{16{readWord[15]}}, readWord[15:0]};
      CorePkg::MemByteU: loadData = {24'b0, readWord[7:0]};
      CorePkg::MemHalfU: loadData = {16'b0, readWord[15:0]};
      default:           loadData = readWord;
    endcase
  end

endmodule

// File: design/DecodeBus.sv
// Decoder results; only valid while the instruction register holds a fetched word
`timescale 1ns/1ps

interface DecodeBus;

  CorePkg::RegAddr rs1Addr;
  CorePkg::RegAddr rs2Addr;
  CorePkg::RegAddr rdAddr;
  logic [CorePkg::DataWidth-1:0] imm;
  CorePkg::OpInfo opInfo;

  modport producer (output rs1Addr, output rs2Addr, output rdAddr, output imm,
                    output opInfo);

  modport consumer (input rs1Addr, input rs2Addr, input rdAddr, input imm,
                    input opInfo);

endinterface

// File: design/Decoder.sv
// RV32I base decode only; unknown opcodes become bubbles, reserved funct3 values are not trapped
`timescale 1ns/1ps

module Decoder (
  input  logic [31:0] instB,
  DecodeBus.producer  bus
);

  CorePkg::OpCode opCode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [31:0] immI;
  logic [31:0] immS;
  logic [31:0] immB;
  logic [31:0] immU;
  logic [31:0] immJ;

  function automatic CorePkg::AluCode aluFor(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? CorePkg::AluSub : CorePkg::AluAdd;
      3'b001:  return CorePkg::AluSll;
      3'b010:  return CorePkg::AluSlt;
      3'b011:  return CorePkg::AluSltu;
      3'b100:  return CorePkg::AluXor;
      3'b101:  return alt ? CorePkg::AluSra : CorePkg::AluSrl;
      3'b110:  return CorePkg::AluOr;
      default: return CorePkg::AluAnd;
    endcase
  endfunction

  function automatic CorePkg::MemWidth widthFor(input logic [2:0] f3);
    case (f3)
      3'b000:  return CorePkg::MemByte;
      3'b001:  return CorePkg::MemHalf;
      3'b010:  return CorePkg::MemWord;
      3'b100:  return CorePkg::MemByteU;
      3'b101:  return CorePkg::MemHalfU;
      default: return CorePkg::MemNone;
    endcase
  endfunction

  assign opCode = CorePkg::OpCode'(instB[6:0]);
  assign funct3 = instB[14:12];
  assign funct7 = instB[31:25];

  assign immI = {{20{instB[31]}}, instB[31:20]};
  assign immS = {{20{instB[31]}}, instB[31:25], instB[11:7]};
  assign immB = {{19{instB[31]}}, instB[31], instB[7], instB[30:25], instB[11:8], 1'b0};
  assign immU = {instB[31:12], 12'b0};
  assign immJ = {{11{instB[31]}}, instB[31], instB[19:12], instB[20], instB[30:21], 1'b0};

  always_comb begin
    bus.rs1Addr = CorePkg::RegNone;
    bus.rs2Addr = CorePkg::RegNone;
    bus.rdAddr = CorePkg::RegNone;
    bus.imm = '0;
    bus.opInfo = '0;

    case (opCode)
      CorePkg::OpcOpImm: begin
        bus.rs1Addr = instB[19:15];
        bus.rdAddr = instB[11:7];
        bus.imm = immI;
        bus.opInfo.op2Sel = CorePkg::SelImm;
        // Bit 30 only selects SRAI; ADDI with a negative immediate also has it set
        bus.opInfo.aluCode = aluFor(funct3, funct7[5] && funct3 == 3'b101);
        bus.opInfo.wEnable = 1'b1;
      end
      CorePkg::OpcOp: begin
        bus.rs1Addr = instB[19:15];
        bus.rs2Addr = instB[24:20];
        bus.rdAddr = instB[11:7];
        bus.opInfo.aluCode = aluFor(funct3, funct7[5]);
        bus.opInfo.wEnable = 1'b1;
      end
      CorePkg::OpcLui, CorePkg::OpcAuipc: begin
        bus.rdAddr = instB[11:7];
        bus.imm = immU;
        bus.opInfo.op1Sel = CorePkg::SelPc;
        bus.opInfo.op2Sel = CorePkg::SelImm;
        bus.opInfo.aluCode = (opCode == CorePkg::OpcLui) ? CorePkg::AluPassB : CorePkg::AluAdd;
        bus.opInfo.wEnable = 1'b1;
      end
      CorePkg::OpcJal: begin
        bus.rdAddr = instB[11:7];
        bus.imm = immJ;
        bus.opInfo.wEnable = 1'b1;
        bus.opInfo.isJump = 1'b1;
      end
      CorePkg::OpcJalr: begin
        bus.rs1Addr = instB[19:15];
        bus.rdAddr = instB[11:7];
        bus.imm = immI;
        bus.opInfo.op2Sel = CorePkg::SelImm;
        bus.opInfo.wEnable = 1'b1;
        bus.opInfo.isJump = 1'b1;
        bus.opInfo.isJalr = 1'b1;
      end
      CorePkg::OpcBranch: begin
        bus.rs1Addr = instB[19:15];
        bus.rs2Addr = instB[24:20];
        bus.imm = immB;
        case (funct3)
          3'b000:  bus.opInfo.brCode = CorePkg::BrEq;
          3'b001:  bus.opInfo.brCode = CorePkg::BrNe;
          3'b100:  bus.opInfo.brCode = CorePkg::BrLt;
          3'b101:  bus.opInfo.brCode = CorePkg::BrGe;
          3'b110:  bus.opInfo.brCode = CorePkg::BrLtu;
          3'b111:  bus.opInfo.brCode = CorePkg::BrGeu;
          default: bus.opInfo.brCode = CorePkg::BrNone;
        endcase
      end
      CorePkg::OpcLoad: begin
        bus.rs1Addr = instB[19:15];
        bus.rdAddr = instB[11:7];
        bus.imm = immI;
        bus.opInfo.op2Sel = CorePkg::SelImm;
        bus.opInfo.memWidth = widthFor(funct3);
        bus.opInfo.wEnable = 1'b1;
        bus.opInfo.isLoad = 1'b1;
      end
      CorePkg::OpcStore: begin
        bus.rs1Addr = instB[19:15];
        bus.rs2Addr = instB[24:20];
        bus.imm = immS;
        bus.opInfo.op2Sel = CorePkg::SelImm;
        // SB, SH and SW share their funct3 codes with the signed loads
        bus.opInfo.memWidth = widthFor({1'b0, funct3[1:0]});
        bus.opInfo.isStore = 1'b1;
      end
      default: begin
        bus.opInfo.isBubble = 1'b1;
      end
    endcase
  end

endmodule

// File: design/RegisterFile.sv
// 32 x 32-bit registers, combinational reads, x0 never written so it always reads zero
`timescale 1ns/1ps

module RegisterFile (
  input  logic                          clk,
  input  logic                          reset,
  input  CorePkg::RegAddr               rs1Addr,
  input  CorePkg::RegAddr               rs2Addr,
  input  CorePkg::RegAddr               writeAddr,
  input  logic                          writeEnable,
  input  logic [CorePkg::DataWidth-1:0] writeData,
  output logic [CorePkg::DataWidth-1:0] rs1Data,
  output logic [CorePkg::DataWidth-1:0] rs2Data
);

  logic [CorePkg::DataWidth-1:0] regs [CorePkg::RegCount];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < CorePkg::RegCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && writeAddr != CorePkg::RegNone) begin
      regs[writeAddr] <= writeData;
    end
  end

  assign rs1Data = regs[rs1Addr];
  assign rs2Data = regs[rs2Addr];

endmodule

// File: design/RiscCore.sv
// Multi-cycle RV32I core; instruction memory sits outside, data memory inside
`timescale 1ns/1ps

module RiscCore (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [31:0]                   fetchData,
  output logic [CorePkg::DataWidth-1:0] fetchAddr,
  output logic                          retire,
  output logic [CorePkg::DataWidth-1:0] retirePc,
  output logic                          retireWrite,
  output CorePkg::RegAddr               retireRd,
  output logic [CorePkg::DataWidth-1:0] retireData
);

  logic [31:0] instB;
  logic [CorePkg::DataWidth-1:0] pc;
  logic [CorePkg::DataWidth-1:0] rs1Data;
  logic [CorePkg::DataWidth-1:0] rs2Data;
  logic [CorePkg::DataWidth-1:0] aluResult;
  logic [CorePkg::DataWidth-1:0] loadData;
  logic [CorePkg::DataWidth-1:0] regWriteData;
  logic taken;
  logic regWrite;
  logic memRead;
  logic memWrite;

  DecodeBus decodeBus ();

  Decoder decoder (
    .instB (instB),
    .bus   (decodeBus.producer)
  );

  RegisterFile regFile (
    .clk         (clk),
    .reset       (reset),
    .rs1Addr     (decodeBus.rs1Addr),
    .rs2Addr     (decodeBus.rs2Addr),
    .writeAddr   (decodeBus.rdAddr),
    .writeEnable (regWrite),
    .writeData   (regWriteData),
    .rs1Data     (rs1Data),
    .rs2Data     (rs2Data)
  );

  Alu alu (
    .bus       (decodeBus.consumer),
    .pc        (pc),
    .rs1Data   (rs1Data),
    .rs2Data   (rs2Data),
    .aluResult (aluResult)
  );

  BranchUnit branchUnit (
    .bus     (decodeBus.consumer),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data),
    .taken   (taken)
  );

  DataMemory dataMemory (
    .clk      (clk),
    .memRead  (memRead),
    .memWrite (memWrite),
    .address  (aluResult),
    .rs2Data  (rs2Data),
    .bus      (decodeBus.consumer),
    .loadData (loadData)
  );

  CoreControl control (
    .clk          (clk),
    .reset        (reset),
    .fetchData    (fetchData),
    .aluResult    (aluResult),
    .loadData     (loadData),
    .taken        (taken),
    .bus          (decodeBus.consumer),
    .fetchAddr    (fetchAddr),
    .instB        (instB),
    .pc           (pc),
    .regWrite     (regWrite),
    .regWriteData (regWriteData),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .retire       (retire),
    .retirePc     (retirePc),
    .retireWrite  (retireWrite),
    .retireRd     (retireRd),
    .retireData   (retireData)
  );

endmodule

// File: riscCore.f
+incdir+testbench
design/CorePkg.sv
design/DecodeBus.sv
design/Decoder.sv
design/RegisterFile.sv
design/Alu.sv
design/BranchUnit.sv
design/DataMemory.sv
design/CoreControl.sv
design/RiscCore.sv
testbench/RiscCore_assert.sv
testbench/RiscCoreTb.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module RiscCoreTb -f riscCore.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "Test passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: testbench/RiscCoreModel.svh
// Instruction-level RV32I reference; aligned loads and stores only, data memory starts at zero
`ifndef RISC_CORE_MODEL_SVH
`define RISC_CORE_MODEL_SVH

logic [31:0] mPc;
logic [31:0] mRegs [32];
logic [31:0] mMem [256];

task automatic resetModel();
  mPc = 32'h0;
  for (int i = 0; i < 32; i++) begin
    mRegs[i] = 32'h0;
  end
  for (int i = 0; i < 256; i++) begin
    mMem[i] = 32'h0;
  end
endtask

function automatic logic [31:0] aluOp(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {31'b0, $signed(a) < $signed(b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    3'b111:  return a >= b;
    default: return 1'b0;
  endcase
endfunction

// Executes one instruction and reports what the core should retire
task automatic stepModel(input logic [31:0] inst, output logic wr, output logic [4:0] rd,
                         output logic [31:0] data, output int cycles);
  logic [2:0] f3;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] immI;
  logic [31:0] immS;
  logic [31:0] immB;
  logic [31:0] immJ;
  logic [31:0] immU;
  logic [31:0] addr;
  logic [31:0] word;
  logic [31:0] nextPc;
  f3 = inst[14:12];
  rd = inst[11:7];
  a = mRegs[inst[19:15]];
  b = mRegs[inst[24:20]];
  immI = {{20{inst[31]}}, inst[31:20]};
  immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  immU = {inst[31:12], 12'b0};
  wr = 1'b0;
  data = 32'h0;
  cycles = 2;
  nextPc = mPc + 32'd4;
  addr = a + immI;
  case (inst[6:0])
    7'b0010011: begin
      wr = 1'b1;
      data = aluOp(f3, inst[30] && f3 == 3'b101, a, immI);
    end
    7'b0110011: begin
      wr = 1'b1;
      data = aluOp(f3, inst[30], a, b);
    end
    7'b0110111: begin
      wr = 1'b1;
      data = immU;
    end
    7'b0010111: begin
      wr = 1'b1;
      data = mPc + immU;
    end
    7'b1101111: begin
      wr = 1'b1;
      data = mPc + 32'd4;
      nextPc = mPc + immJ;
    end
    7'b1100111: begin
      wr = 1'b1;
      data = mPc + 32'd4;
      nextPc = addr & ~32'd1;
    end
    7'b1100011: begin
      if (branchTaken(f3, a, b)) begin
        nextPc = mPc + immB;
      end
    end
    7'b0000011: begin
      cycles = 4;
      wr = 1'b1;
      word = mMem[addr[9:2]] >> (8 * addr[1:0]);
      case (f3)
        3'b000:  data = {{24{word[7]}}, word[7:0]};
        3'b001:  data = {{16{word[15]}}, word[15:0]};
        3'b100:  data = {24'b0, word[7:0]};
        3'b101:  data = {16'b0, word[15:0]};
        default: data = word;
      endcase
    end
    7'b0100011: begin
      cycles = 3;
      addr = a + immS;
      case (f3)
        3'b000:  mMem[addr[9:2]][8 * addr[1:0] +: 8] = b[7:0];
        3'b001:  mMem[addr[9:2]][16 * addr[1] +: 16] = b[15:0];
        default: mMem[addr[9:2]] = b;
      endcase
    end
    default: begin
      // Illegal word, nothing changes but the PC
    end
  endcase
  if (wr && rd != 5'd0) begin
    mRegs[rd] = data;
  end else begin
    wr = 1'b0;
  end
  mPc = nextPc;
endtask

`endif

// File: testbench/RiscCoreTb.sv
// Random 64-word program with forward branches; loads and stores stay within bytes 0 to 31
`timescale 1ns/1ps

module RiscCoreTb;

  localparam int ProgWords = 64;
  localparam int RetireTarget = 3000;
  localparam int CycleLimit = RetireTarget * 4 + 200;

  logic clk;
  logic reset;
  logic [31:0] fetchData;
  logic [31:0] fetchAddr;
  logic retire;
  logic [31:0] retirePc;
  logic retireWrite;
  logic [4:0] retireRd;
  logic [31:0] retireData;

  logic [31:0] imem [ProgWords];
  int valueErrors;
  int lostRetires;
  int retireCount;
  int cycleCount;
  int gap;

  `include "RiscCoreModel.svh"

  RiscCore i_dut (
    .clk         (clk),
    .reset       (reset),
    .fetchData   (fetchData),
    .fetchAddr   (fetchAddr),
    .retire      (retire),
    .retirePc    (retirePc),
    .retireWrite (retireWrite),
    .retireRd    (retireRd),
    .retireData  (retireData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // x0 now and then, x31 kept for JALR bases
  function automatic logic [4:0] pickRd();
    if ($urandom_range(0, 15) == 0) begin
      return 5'd0;
    end
    return 5'($urandom_range(1, 30));
  endfunction

  function automatic logic [4:0] pickRs();
    return 5'($urandom_range(0, 31));
  endfunction

  function automatic logic [31:0] randomOpImm();
    logic [2:0] f3;
    logic [11:0] imm;
    f3 = 3'($urandom_range(0, 7));
    imm = 12'($urandom);
    if (f3 == 3'b001) begin
      imm[11:5] = 7'h00;
    end
    if (f3 == 3'b101) begin
      imm[11:5] = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
    end
    return encI(imm, pickRs(), f3, pickRd(), 7'b0010011);
  endfunction

  function automatic logic [31:0] randomOp();
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = 3'($urandom_range(0, 7));
    f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
    return {f7, pickRs(), pickRs(), f3, pickRd(), 7'b0110011};
  endfunction

  // Aligned offsets inside the zeroed region
  function automatic logic [11:0] memOffset(input logic [1:0] size);
    case (size)
      2'd0:    return 12'($urandom_range(0, 31));
      2'd1:    return 12'($urandom_range(0, 15) * 2);
      default: return 12'($urandom_range(0, 7) * 4);
    endcase
  endfunction

  task automatic buildProgram();
    int slot;
    int kind;
    int target;
    logic [2:0] f3;
    logic [2:0] brCodes [6];
    brCodes = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    // Prologue clears the data words used by the program
    for (slot = 0; slot < 8; slot++) begin
      imem[slot] = encS(12'(slot * 4), 5'd0, 5'd0, 3'b010);
    end
    slot = 8;
    while (slot < ProgWords) begin
      kind = $urandom_range(0, 99);
      if (kind < 28) begin
        imem[slot] = randomOpImm();
      end else if (kind < 42) begin
        imem[slot] = randomOp();
      end else if (kind < 46) begin
        imem[slot] = {20'($urandom), pickRd(), 7'b0110111};
      end else if (kind < 50) begin
        imem[slot] = {20'($urandom), pickRd(), 7'b0010111};
      end else if (kind < 60) begin
        f3 = brCodes[$urandom_range(0, 5)];
        imem[slot] = encB(13'($urandom_range(1, 6) * 4), pickRs(), pickRs(), f3);
      end else if (kind < 64) begin
        imem[slot] = encJ(21'($urandom_range(1, 6) * 4), pickRd());
      end else if (kind < 70) begin
        if (slot < ProgWords - 1) begin
          target = slot + $urandom_range(2, 8);
          imem[slot] = encI(12'(target * 4), 5'd0, 3'b000, 5'd31, 7'b0010011);
          imem[slot + 1] = encI(12'($urandom_range(0, 1)), 5'd31, 3'b000, pickRd(),
                                7'b1100111);
          slot++;
        end else begin
          imem[slot] = randomOpImm();
        end
      end else if (kind < 80) begin
        f3 = 3'($urandom_range(0, 2));
        imem[slot] = encS(memOffset(f3[1:0]), pickRs(), 5'd0, f3);
      end else if (kind < 95) begin
        // LB, LH, LW, LHU from 0 to 4, LBU from 100
        f3 = 3'($urandom_range(0, 4));
        if (f3 == 3'b011) begin
          f3 = 3'b101;
        end
        imem[slot] = encI(memOffset(f3[1:0]), 5'd0, f3, pickRd(), 7'b0000011);
      end else if (kind < 97) begin
        imem[slot] = randomOpImm();
      end else begin
        // custom-0 opcode, unknown to the core
        imem[slot] = {25'($urandom), 7'b0001011};
      end
      slot++;
    end
  endtask

  always @(posedge clk) begin : checkRetire
    logic expWrite;
    logic [4:0] expRd;
    logic [31:0] expData;
    logic [31:0] expPc;
    int expCycles;
    if (reset) begin
      gap = 0;
    end else begin
      gap = gap + 1;
      if (retire) begin
        expPc = mPc;
        stepModel(imem[expPc[7:2]], expWrite, expRd, expData, expCycles);
        if (retirePc !== expPc) begin
          $display("FAILED at %0t: retirePc %h, expected %h", $time, retirePc, expPc);
          valueErrors++;
        end
        if (fetchAddr !== expPc) begin
          $display("FAILED at %0t: fetchAddr %h, expected %h", $time, fetchAddr, expPc);
          valueErrors++;
        end
        if (retireWrite !== expWrite) begin
          $display("FAILED at %0t: retireWrite %b, expected %b at pc %h", $time,
                   retireWrite, expWrite, expPc);
          valueErrors++;
        end
        if (expWrite && retireRd !== expRd) begin
          $display("FAILED at %0t: retireRd %0d, expected %0d", $time, retireRd, expRd);
          valueErrors++;
        end
        if (expWrite && retireData !== expData) begin
          $display("FAILED at %0t: retireData %h, expected %h at pc %h", $time,
                   retireData, expData, expPc);
          valueErrors++;
        end
        if (gap != expCycles) begin
          $display("FAILED at %0t: retire after %0d cycles, expected %0d", $time, gap,
                   expCycles);
          valueErrors++;
        end
        gap = 0;
        retireCount++;
        fetchData <= imem[mPc[7:2]];
      end else if (gap > 4) begin
        $display("No retire seen for more than four cycles at %0t", $time);
        lostRetires++;
        gap = 0;
      end
    end
  end

  initial begin
    void'($urandom(20));
    valueErrors = 0;
    lostRetires = 0;
    retireCount = 0;
    cycleCount = 0;
    gap = 0;
    buildProgram();
    resetModel();
    reset = 1'b1;
    fetchData = imem[0];
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    while (retireCount < RetireTarget && cycleCount < CycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    if (cycleCount >= CycleLimit) begin
      $display("Timeout after %0d cycles with %0d retires", cycleCount, retireCount);
    end
    $display("Value errors %0d, missing retires %0d, retires %0d", valueErrors,
             lostRetires, retireCount);
    if (valueErrors == 0 && lostRetires == 0 && cycleCount < CycleLimit) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: testbench/RiscCore_assert.sv
// Bound into CoreControl; checks hold only after the first reset edge
`timescale 1ns/1ps

module ControlChecks (
  input logic              clk,
  input logic              reset,
  input CorePkg::CoreState state,
  input logic              retire,
  input logic              regWrite,
  input logic              memRead,
  input logic              memWrite
);

  retirePulse: assert property (@(posedge clk) disable iff (reset) retire |=> !retire)
    else $error("retire held longer than one cycle");

  // A store reaches Memory straight from Execute
  writeInMemory: assert property (@(posedge clk) disable iff (reset)
      memWrite |-> state == CorePkg::StMemory && $past(state) == CorePkg::StExecute)
    else $error("memWrite outside the Memory state");

  // One cycle after a reset edge the FSM sits in Fetch
  quietReset: assert property (@(posedge clk)
      reset |=> !retire && !regWrite && !memRead && !memWrite)
    else $error("activity during reset");

endmodule

bind CoreControl ControlChecks checks (
  .clk      (clk),
  .reset    (reset),
  .state    (state),
  .retire   (retire),
  .regWrite (regWrite),
  .memRead  (memRead),
  .memWrite (memWrite)
);
